// File: common/idct_pkg.sv
// IDCT datapath types: coefficient, product, pixel, index and RAM word
// cosine table, pass scaling shifts and the block sequencer states
package idct_pkg;

	typedef logic signed [15:0] coef_t;
	typedef logic signed [31:0] prod_t;
	typedef logic [7:0] pixel_t;
	typedef logic [2:0] idx_t;

	// 0..63 hold one matrix, 64..127 the other
	typedef logic [6:0] dp_addr_t;
	typedef logic [31:0] dp_data_t;

	// round(4096 * k(i) * cos((2j+1) * i * pi / 16)), indexed [i][j]
	localparam coef_t C_TABLE [8][8] = '{
		'{16'sd1448, 16'sd1448, 16'sd1448, 16'sd1448,
		  16'sd1448, 16'sd1448, 16'sd1448, 16'sd1448},
		'{16'sd2009, 16'sd1703, 16'sd1138, 16'sd400,
		  -16'sd400, -16'sd1138, -16'sd1703, -16'sd2009},
		'{16'sd1892, 16'sd784, -16'sd784, -16'sd1892,
		  -16'sd1892, -16'sd784, 16'sd784, 16'sd1892},
		'{16'sd1703, -16'sd400, -16'sd2009, -16'sd1138,
		  16'sd1138, 16'sd2009, 16'sd400, -16'sd1703},
		'{16'sd1448, -16'sd1448, -16'sd1448, 16'sd1448,
		  16'sd1448, -16'sd1448, -16'sd1448, 16'sd1448},
		'{16'sd1138, -16'sd2009, 16'sd400, 16'sd1703,
		  -16'sd1703, -16'sd400, 16'sd2009, -16'sd1138},
		'{16'sd784, -16'sd1892, 16'sd1892, -16'sd784,
		  -16'sd784, 16'sd1892, -16'sd1892, 16'sd784},
		'{16'sd400, -16'sd1138, 16'sd1703, -16'sd2009,
		  16'sd2009, -16'sd1703, 16'sd1138, -16'sd400}
	};

	// arithmetic right shifts after each pass
	localparam int T_SHIFT = 8;
	localparam int S_SHIFT = 16;

	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		COMPUTE,
		WRITE,
		DONE
	} block_state_t;

endpackage

// File: common/sram_pkg.sv
// external SRAM address and data types
// Y plane and pre-IDCT coefficient layout in the image memory
package sram_pkg;

	typedef logic [17:0] sram_addr_t;
	typedef logic [15:0] sram_data_t;

	// 320x240 image, 8x8 blocks
	localparam int BLOCKS_PER_ROW = 40;

	// signed coefficients, one per word
	localparam sram_addr_t PRE_IDCT_BASE = 18'd76800;
	localparam sram_addr_t PRE_ROW_STRIDE = sram_addr_t'(BLOCKS_PER_ROW * 8);

	// Y pixels, two per word
	localparam sram_addr_t Y_BASE = 18'd0;
	localparam sram_addr_t Y_ROW_STRIDE = sram_addr_t'(BLOCKS_PER_ROW * 4);

endpackage

// File: hw/dp_ram.sv
// dual-port RAM, 128 x 32
// write-first ports with registered read data
`timescale 1ns/10ps

module dp_ram (
	input  logic               Clock,
	input  idct_pkg::dp_addr_t addr_a_i,
	input  idct_pkg::dp_addr_t addr_b_i,
	input  idct_pkg::dp_data_t wdata_a_i,
	input  idct_pkg::dp_data_t wdata_b_i,
	input  logic               we_a_i,
	input  logic               we_b_i,
	output idct_pkg::dp_data_t rdata_a_o,
	output idct_pkg::dp_data_t rdata_b_o
);

	idct_pkg::dp_data_t mem [128];

	always_ff @(posedge Clock) begin
		if (we_a_i) begin
			mem[addr_a_i] <= wdata_a_i;
			rdata_a_o <= wdata_a_i;
		end else begin
			rdata_a_o <= mem[addr_a_i];
		end
		// port b wins on a same-address write
		if (we_b_i) begin
			mem[addr_b_i] <= wdata_b_i;
			rdata_b_o <= wdata_b_i;
		end else begin
			rdata_b_o <= mem[addr_b_i];
		end
	end

endmodule

// File: hw/idct/coef_fetch.sv
// coefficient block fetch
// 64 back-to-back SRAM reads, row-major, into the coefficient RAM
`timescale 1ns/10ps

module coef_fetch (
	input  logic                 Clock,
	input  logic                 Resetn,
	input  logic                 go_i,
	input  logic [5:0]           block_col_i,
	input  logic [4:0]           block_row_i,
	output sram_pkg::sram_addr_t sram_addr_o,
	input  sram_pkg::sram_data_t sram_rdata_i,
	output idct_pkg::dp_addr_t   ram_addr_o,
	output idct_pkg::dp_data_t   ram_wdata_o,
	output logic                 ram_we_o,
	output logic                 fin_o
);

	logic active;
	// {row, col} of the element being addressed
	logic [5:0] cnt;
	sram_pkg::sram_addr_t blk_base;
	sram_pkg::sram_addr_t row_base;
	logic [1:0] vld;
	logic [1:0] last;
	logic [5:0] idx [2];

	assign blk_base = sram_pkg::PRE_IDCT_BASE
		+ sram_pkg::sram_addr_t'({block_row_i, 3'b000}) * sram_pkg::PRE_ROW_STRIDE
		+ sram_pkg::sram_addr_t'({block_col_i, 3'b000});

	assign sram_addr_o = row_base + sram_pkg::sram_addr_t'(cnt[2:0]);

	// data returns two cycles after its address
	assign ram_addr_o = {1'b0, idx[1]};
	assign ram_we_o = vld[1];
	assign ram_wdata_o = idct_pkg::prod_t'(idct_pkg::coef_t'(sram_rdata_i));

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			active <= 1'b0;
			cnt <= '0;
			vld <= '0;
			last <= '0;
			fin_o <= 1'b0;
		end else begin
			vld <= {vld[0], active};
			last <= {last[0], active && (cnt == 6'd63)};
			fin_o <= last[1];
			if (active) begin
				cnt <= cnt + 6'd1;
				if (cnt == 6'd63) begin
					active <= 1'b0;
				end
			end
			if (go_i) begin
				active <= 1'b1;
				cnt <= '0;
			end
		end
	end

	always_ff @(posedge Clock) begin
		idx[0] <= cnt;
		idx[1] <= idx[0];
		if (go_i) begin
			row_base <= blk_base;
		end else if (active && (cnt[2:0] == 3'd7)) begin
			row_base <= row_base + sram_pkg::PRE_ROW_STRIDE;
		end
	end

endmodule

// File: hw/idct/idct_compute.sv
// two-pass 8x8 IDCT, T = S'.C then S = C^T.T
// line loader with a next-line buffer, two multipliers per cycle
`timescale 1ns/10ps

module idct_compute (
	input  logic               Clock,
	input  logic               Resetn,
	input  logic               go_i,
	output idct_pkg::dp_addr_t coef_addr_o,
	input  idct_pkg::dp_data_t coef_rdata_a_i,
	input  idct_pkg::dp_data_t coef_rdata_b_i,
	output idct_pkg::dp_addr_t res_addr_a_o,
	output idct_pkg::dp_addr_t res_addr_b_o,
	output idct_pkg::dp_data_t res_wdata_o,
	output logic               res_we_o,
	input  idct_pkg::dp_data_t res_rdata_b_i,
	output logic               fin_o
);

	// low while forming T, high while forming S
	logic pass_q;

	// loader: row of S' in pass 1, column of T in pass 2
	logic ld_act;
	idct_pkg::idx_t ld_line;
	idct_pkg::idx_t ld_cnt;
	logic ld_last;
	logic [1:0] ld_v;
	logic [1:0] ld_fin;
	idct_pkg::idx_t ld_k [2];
	logic nxt_full;

	idct_pkg::prod_t buf_nxt [8];
	idct_pkg::prod_t buf_cur [8];

	// compute engine
	logic cmp_act;
	idct_pkg::idx_t cur_line;
	idct_pkg::idx_t out_idx;
	logic [1:0] kp;
	idct_pkg::prod_t acc;

	idct_pkg::idx_t k0;
	idct_pkg::idx_t k1;
	idct_pkg::prod_t prod0;
	idct_pkg::prod_t prod1;
	idct_pkg::prod_t acc_in;
	idct_pkg::prod_t sum;
	idct_pkg::prod_t t_val;
	idct_pkg::prod_t s_val;
	idct_pkg::pixel_t s_pix;
	logic elem_done;
	logic line_done;
	logic swap;

	// pass 1 reads S' in pairs, pass 2 reads T one word at a time
	assign ld_last = pass_q ? (ld_cnt == 3'd7) : (ld_cnt == 3'd3);

	// same cosine lookup C(k, out_idx) in both passes
	assign k0 = {kp, 1'b0};
	assign k1 = {kp, 1'b1};
	assign prod0 = buf_cur[k0] * idct_pkg::prod_t'(idct_pkg::C_TABLE[k0][out_idx]);
	assign prod1 = buf_cur[k1] * idct_pkg::prod_t'(idct_pkg::C_TABLE[k1][out_idx]);
	assign acc_in = (kp == 2'd0) ? '0 : acc;
	assign sum = acc_in + prod0 + prod1;

	assign t_val = sum >>> idct_pkg::T_SHIFT;
	assign s_val = sum >>> idct_pkg::S_SHIFT;

	always_comb begin
		if (s_val < 0) begin
			s_pix = '0;
		end else if (s_val > 255) begin
			s_pix = 8'd255;
		end else begin
			s_pix = s_val[7:0];
		end
	end

	assign elem_done = cmp_act && (kp == 2'd3);
	assign line_done = elem_done && (out_idx == 3'd7);
	assign swap = nxt_full && (!cmp_act || line_done);

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			pass_q <= 1'b0;
			ld_act <= 1'b0;
			ld_line <= '0;
			ld_cnt <= '0;
			ld_v <= '0;
			ld_fin <= '0;
			nxt_full <= 1'b0;
			cmp_act <= 1'b0;
			cur_line <= '0;
			out_idx <= '0;
			kp <= '0;
			res_we_o <= 1'b0;
			fin_o <= 1'b0;
		end else begin
			res_we_o <= 1'b0;
			fin_o <= 1'b0;
			ld_v <= {ld_v[0], ld_act};
			ld_fin <= {ld_fin[0], ld_act && ld_last};
			if (ld_act) begin
				ld_cnt <= ld_cnt + 3'd1;
				if (ld_last) begin
					ld_act <= 1'b0;
				end
			end
			if (ld_fin[1]) begin
				nxt_full <= 1'b1;
			end
			if (cmp_act) begin
				kp <= kp + 2'd1;
				if (kp == 2'd3) begin
					out_idx <= out_idx + 3'd1;
					res_we_o <= 1'b1;
				end
				if (line_done) begin
					cmp_act <= 1'b0;
					// last line of a pass
					if (cur_line == 3'd7) begin
						if (pass_q) begin
							fin_o <= 1'b1;
						end else begin
							pass_q <= 1'b1;
							ld_act <= 1'b1;
							ld_line <= '0;
							ld_cnt <= '0;
						end
					end
				end
			end
			if (go_i) begin
				pass_q <= 1'b0;
				ld_act <= 1'b1;
				ld_line <= '0;
				ld_cnt <= '0;
			end
			if (swap) begin
				nxt_full <= 1'b0;
				cmp_act <= 1'b1;
				cur_line <= ld_line;
				out_idx <= '0;
				kp <= '0;
				// next line loads while this one accumulates
				if (ld_line != 3'd7) begin
					ld_act <= 1'b1;
					ld_line <= ld_line + 3'd1;
					ld_cnt <= '0;
				end
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (ld_act) begin
			coef_addr_o <= {1'b0, ld_line, ld_cnt[1:0], 1'b0};
			res_addr_b_o <= {1'b1, ld_cnt, ld_line};
		end
		ld_k[0] <= ld_cnt;
		ld_k[1] <= ld_k[0];
		if (ld_v[1]) begin
			if (pass_q) begin
				buf_nxt[ld_k[1]] <= res_rdata_b_i;
			end else begin
				buf_nxt[{ld_k[1][1:0], 1'b0}] <= coef_rdata_a_i;
				buf_nxt[{ld_k[1][1:0], 1'b1}] <= coef_rdata_b_i;
			end
		end
		if (swap) begin
			buf_cur <= buf_nxt;
		end
		if (cmp_act) begin
			acc <= sum;
		end
		if (elem_done) begin
			if (pass_q) begin
				res_addr_a_o <= {1'b0, out_idx, cur_line};
				res_wdata_o <= idct_pkg::dp_data_t'(s_pix);
			end else begin
				res_addr_a_o <= {1'b1, cur_line, out_idx};
				res_wdata_o <= t_val;
			end
		end
	end

endmodule

// File: hw/idct/pixel_writeback.sv
// pixel writeback from the result RAM to the Y plane
// even pixel in the high byte, one SRAM write per pair
`timescale 1ns/10ps

module pixel_writeback (
	input  logic                 Clock,
	input  logic                 Resetn,
	input  logic                 go_i,
	input  logic [5:0]           block_col_i,
	input  logic [4:0]           block_row_i,
	output idct_pkg::dp_addr_t   ram_addr_o,
	input  idct_pkg::dp_data_t   ram_rdata_i,
	output sram_pkg::sram_addr_t sram_addr_o,
	output sram_pkg::sram_data_t sram_wdata_o,
	output logic                 sram_we_n_o,
	output logic                 fin_o
);

	logic active;
	logic [5:0] rd_cnt;
	logic vld;
	logic [5:0] rd_idx;
	logic [1:0] last_d;
	idct_pkg::pixel_t even_q;
	sram_pkg::sram_addr_t base_q;

	assign ram_addr_o = {1'b0, rd_cnt};

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			active <= 1'b0;
			rd_cnt <= '0;
			vld <= 1'b0;
			last_d <= '0;
			sram_we_n_o <= 1'b1;
			fin_o <= 1'b0;
		end else begin
			vld <= active;
			// odd read completes a pair
			sram_we_n_o <= !(vld && rd_idx[0]);
			last_d <= {last_d[0], vld && (rd_idx == 6'd63)};
			fin_o <= last_d[1];
			if (active) begin
				rd_cnt <= rd_cnt + 6'd1;
				if (rd_cnt == 6'd63) begin
					active <= 1'b0;
				end
			end
			if (go_i) begin
				active <= 1'b1;
				rd_cnt <= '0;
			end
		end
	end

	always_ff @(posedge Clock) begin
		rd_idx <= rd_cnt;
		if (go_i) begin
			base_q <= sram_pkg::Y_BASE
				+ sram_pkg::sram_addr_t'({block_row_i, 3'b000}) * sram_pkg::Y_ROW_STRIDE
				+ sram_pkg::sram_addr_t'({block_col_i, 2'b00});
		end
		if (vld && !rd_idx[0]) begin
			even_q <= ram_rdata_i[7:0];
		end
		if (vld && rd_idx[0]) begin
			sram_wdata_o <= {even_q, ram_rdata_i[7:0]};
			sram_addr_o <= base_q
				+ sram_pkg::sram_addr_t'(rd_idx[5:3]) * sram_pkg::Y_ROW_STRIDE
				+ sram_pkg::sram_addr_t'(rd_idx[2:1]);
		end
	end

endmodule

// File: hw/idct_block_top.sv
// 8x8 IDCT block engine top level
// fetch/compute/writeback sequencer, SRAM port mux and the two block RAMs
`timescale 1ns/10ps

module idct_block_top (
	input  logic                 Clock,
	input  logic                 Resetn,
	input  logic                 start_i,
	input  logic [5:0]           block_col_i,
	input  logic [4:0]           block_row_i,
	output sram_pkg::sram_addr_t sram_addr_o,
	input  sram_pkg::sram_data_t sram_rdata_i,
	output sram_pkg::sram_data_t sram_wdata_o,
	output logic                 sram_we_n_o,
	output logic                 done_o
);

	idct_pkg::block_state_t state;
	logic [5:0] blk_col_q;
	logic [4:0] blk_row_q;
	logic fetch_go;
	logic comp_go;
	logic wb_go;
	logic fetch_fin;
	logic comp_fin;
	logic wb_fin;

	sram_pkg::sram_addr_t fetch_sram_addr;
	sram_pkg::sram_addr_t wb_sram_addr;
	sram_pkg::sram_data_t wb_sram_wdata;
	logic wb_sram_we_n;

	idct_pkg::dp_addr_t fetch_ram_addr;
	idct_pkg::dp_data_t fetch_ram_wdata;
	logic fetch_ram_we;
	idct_pkg::dp_addr_t comp_coef_addr;
	idct_pkg::dp_addr_t coef_addr_a;
	idct_pkg::dp_data_t coef_rdata_a;
	idct_pkg::dp_data_t coef_rdata_b;

	idct_pkg::dp_addr_t comp_res_addr_a;
	idct_pkg::dp_addr_t comp_res_addr_b;
	idct_pkg::dp_data_t comp_res_wdata;
	logic comp_res_we;
	idct_pkg::dp_addr_t wb_ram_addr;
	idct_pkg::dp_addr_t res_addr_a;
	idct_pkg::dp_data_t res_rdata_a;
	idct_pkg::dp_data_t res_rdata_b;

	// port a is shared by the writer and one of the readers
	assign coef_addr_a = (state == idct_pkg::FETCH) ? fetch_ram_addr : comp_coef_addr;
	assign res_addr_a = (state == idct_pkg::WRITE) ? wb_ram_addr : comp_res_addr_a;

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state <= idct_pkg::IDLE;
			fetch_go <= 1'b0;
			comp_go <= 1'b0;
			wb_go <= 1'b0;
			done_o <= 1'b0;
			sram_we_n_o <= 1'b1;
		end else begin
			fetch_go <= 1'b0;
			comp_go <= 1'b0;
			wb_go <= 1'b0;
			done_o <= 1'b0;
			sram_we_n_o <= (state == idct_pkg::FETCH) || wb_sram_we_n;
			case (state)
				idct_pkg::IDLE: begin
					if (start_i) begin
						fetch_go <= 1'b1;
						state <= idct_pkg::FETCH;
					end
				end
				idct_pkg::FETCH: begin
					if (fetch_fin) begin
						comp_go <= 1'b1;
						state <= idct_pkg::COMPUTE;
					end
				end
				idct_pkg::COMPUTE: begin
					if (comp_fin) begin
						wb_go <= 1'b1;
						state <= idct_pkg::WRITE;
					end
				end
				idct_pkg::WRITE: begin
					if (wb_fin) begin
						done_o <= 1'b1;
						state <= idct_pkg::DONE;
					end
				end
				default: begin
					state <= idct_pkg::IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		if ((state == idct_pkg::IDLE) && start_i) begin
			blk_col_q <= block_col_i;
			blk_row_q <= block_row_i;
		end
		sram_addr_o <= (state == idct_pkg::FETCH) ? fetch_sram_addr : wb_sram_addr;
		sram_wdata_o <= wb_sram_wdata;
	end

	dp_ram u_coef_ram (
		.Clock     (Clock),
		.addr_a_i  (coef_addr_a),
		.addr_b_i  ({comp_coef_addr[6:1], 1'b1}),
		.wdata_a_i (fetch_ram_wdata),
		.wdata_b_i ('0),
		.we_a_i    (fetch_ram_we),
		.we_b_i    (1'b0),
		.rdata_a_o (coef_rdata_a),
		.rdata_b_o (coef_rdata_b)
	);

	dp_ram u_res_ram (
		.Clock     (Clock),
		.addr_a_i  (res_addr_a),
		.addr_b_i  (comp_res_addr_b),
		.wdata_a_i (comp_res_wdata),
		.wdata_b_i ('0),
		.we_a_i    (comp_res_we),
		.we_b_i    (1'b0),
		.rdata_a_o (res_rdata_a),
		.rdata_b_o (res_rdata_b)
	);

	coef_fetch u_coef_fetch (
		.Clock        (Clock),
		.Resetn       (Resetn),
		.go_i         (fetch_go),
		.block_col_i  (blk_col_q),
		.block_row_i  (blk_row_q),
		.sram_addr_o  (fetch_sram_addr),
		.sram_rdata_i (sram_rdata_i),
		.ram_addr_o   (fetch_ram_addr),
		.ram_wdata_o  (fetch_ram_wdata),
		.ram_we_o     (fetch_ram_we),
		.fin_o        (fetch_fin)
	);

	idct_compute u_idct_compute (
		.Clock          (Clock),
		.Resetn         (Resetn),
		.go_i           (comp_go),
		.coef_addr_o    (comp_coef_addr),
		.coef_rdata_a_i (coef_rdata_a),
		.coef_rdata_b_i (coef_rdata_b),
		.res_addr_a_o   (comp_res_addr_a),
		.res_addr_b_o   (comp_res_addr_b),
		.res_wdata_o    (comp_res_wdata),
		.res_we_o       (comp_res_we),
		.res_rdata_b_i  (res_rdata_b),
		.fin_o          (comp_fin)
	);

	pixel_writeback u_pixel_writeback (
		.Clock        (Clock),
		.Resetn       (Resetn),
		.go_i         (wb_go),
		.block_col_i  (blk_col_q),
		.block_row_i  (blk_row_q),
		.ram_addr_o   (wb_ram_addr),
		.ram_rdata_i  (res_rdata_a),
		.sram_addr_o  (wb_sram_addr),
		.sram_wdata_o (wb_sram_wdata),
		.sram_we_n_o  (wb_sram_we_n),
		.fin_o        (wb_fin)
	);

endmodule

// File: verification/sram_model.sv
// behavioural image SRAM, 262144 x 16
// active-low write enable, one-cycle registered read
`timescale 1ns/10ps

module sram_model (
	input  logic                 Clock,
	input  sram_pkg::sram_addr_t addr_i,
	input  sram_pkg::sram_data_t wdata_i,
	input  logic                 we_n_i,
	output sram_pkg::sram_data_t rdata_o
);

	sram_pkg::sram_data_t mem [262144];

	// read returns the old word on a write cycle
	always @(posedge Clock) begin
		if (!we_n_i) begin
			mem[addr_i] <= wdata_i;
		end
		rdata_o <= mem[addr_i];
	end

endmodule

// File: verification/idct_block_tb.sv
// testbench for the 8x8 IDCT block engine
// stimulus table, golden IDCT, SRAM readback checks and result line
`timescale 1ns/10ps

module idct_block_tb;

	localparam int N_TESTS = 7;
	localparam int TIMEOUT = 5000;
	localparam int MEM_WORDS = 262144;
	localparam int MODE_CONST = 0;
	localparam int MODE_DC = 1;
	localparam int MODE_RAND = 2;
	localparam int MODE_EXT = 3;

	// block col/row, fill mode and value, flat pixel or -1, extra start while busy
	int tbl_col [N_TESTS] = '{0, 5, 17, 2, 3, 39, 20};
	int tbl_row [N_TESTS] = '{0, 3, 9, 1, 1, 29, 15};
	int tbl_mode [N_TESTS] = '{MODE_CONST, MODE_DC, MODE_RAND, MODE_DC, MODE_DC,
		MODE_RAND, MODE_EXT};
	int tbl_val [N_TESTS] = '{0, 1024, 512, 32767, -32768, 512, 1000};
	int tbl_flat [N_TESTS] = '{0, 127, -1, 255, 0, -1, -1};
	int tbl_busy [N_TESTS] = '{0, 1, 0, 0, 0, 0, 0};

	logic Clock = 1'b0;
	logic Resetn;
	logic start_i;
	logic [5:0] block_col_i;
	logic [4:0] block_row_i;
	sram_pkg::sram_addr_t sram_addr;
	sram_pkg::sram_data_t sram_rdata;
	sram_pkg::sram_data_t sram_wdata;
	logic sram_we_n;
	logic done_o;

	int coef_blk [64];
	int pix_gold [64];
	logic [31:0] rng_state = 32'h40c4_b648;
	int errors = 0;
	int timeouts = 0;
	int done_cnt = 0;

	always #2 Clock = ~Clock;

	always @(negedge Clock) begin
		if (done_o) begin
			done_cnt <= done_cnt + 1;
		end
	end

	idct_block_top u_dut (
		.Clock        (Clock),
		.Resetn       (Resetn),
		.start_i      (start_i),
		.block_col_i  (block_col_i),
		.block_row_i  (block_row_i),
		.sram_addr_o  (sram_addr),
		.sram_rdata_i (sram_rdata),
		.sram_wdata_o (sram_wdata),
		.sram_we_n_o  (sram_we_n),
		.done_o       (done_o)
	);

	sram_model u_sram (
		.Clock   (Clock),
		.addr_i  (sram_addr),
		.wdata_i (sram_wdata),
		.we_n_i  (sram_we_n),
		.rdata_o (sram_rdata)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// background pattern mixing every address bit
	function automatic sram_pkg::sram_data_t fill_word(input int a);
		logic [17:0] av;
		av = 18'(a);
		return av[15:0] ^ av[17:2] ^ 16'h5a5a;
	endfunction

	task automatic check_pixel(input idct_pkg::pixel_t got, input idct_pkg::pixel_t exp,
			input string name);
		if (got !== exp) begin
			$display("ERROR at %0t: %s = %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_word(input sram_pkg::sram_data_t got,
			input sram_pkg::sram_data_t exp, input string name);
		if (got !== exp) begin
			$display("ERROR at %0t: %s = 0x%04h, expected 0x%04h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input int got, input int exp, input string name);
		if (got != exp) begin
			$display("ERROR at %0t: %s = %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic make_block(input int t);
		int r;
		int c;
		int v;
		for (r = 0; r < 8; r++) begin
			for (c = 0; c < 8; c++) begin
				case (tbl_mode[t])
					MODE_CONST: v = tbl_val[t];
					MODE_DC: v = (r == 0 && c == 0) ? tbl_val[t] : 0;
					MODE_RAND: begin
						rng_state = lcg_next(rng_state);
						v = int'(rng_state[31:22]) - tbl_val[t];
					end
					// checkerboard of +/- value
					default: v = ((r + c) % 2 != 0) ? -tbl_val[t] : tbl_val[t];
				endcase
				coef_blk[6'(r * 8 + c)] = v;
			end
		end
	endtask

	// T = S'.C >>> 8, then S = C^T.T >>> 16 clipped to a byte
	task automatic golden_idct();
		longint t_mat [64];
		longint acc;
		int i;
		int j;
		int k;
		for (i = 0; i < 8; i++) begin
			for (j = 0; j < 8; j++) begin
				acc = 0;
				for (k = 0; k < 8; k++) begin
					acc += longint'(coef_blk[6'(i * 8 + k)])
						* longint'(idct_pkg::C_TABLE[3'(k)][3'(j)]);
				end
				t_mat[6'(i * 8 + j)] = acc >>> idct_pkg::T_SHIFT;
			end
		end
		for (i = 0; i < 8; i++) begin
			for (j = 0; j < 8; j++) begin
				acc = 0;
				for (k = 0; k < 8; k++) begin
					acc += longint'(idct_pkg::C_TABLE[3'(k)][3'(i)]) * t_mat[6'(k * 8 + j)];
				end
				acc = acc >>> idct_pkg::S_SHIFT;
				if (acc < 0) begin
					pix_gold[6'(i * 8 + j)] = 0;
				end else if (acc > 255) begin
					pix_gold[6'(i * 8 + j)] = 255;
				end else begin
					pix_gold[6'(i * 8 + j)] = int'(acc);
				end
			end
		end
	endtask

	task automatic load_memory(input int t);
		int a;
		int base;
		int r;
		int c;
		base = int'(sram_pkg::PRE_IDCT_BASE) + tbl_row[t] * 8 * int'(sram_pkg::PRE_ROW_STRIDE)
			+ tbl_col[t] * 8;
		for (a = 0; a < MEM_WORDS; a++) begin
			u_sram.mem[18'(a)] <= fill_word(a);
		end
		for (r = 0; r < 8; r++) begin
			for (c = 0; c < 8; c++) begin
				a = base + r * int'(sram_pkg::PRE_ROW_STRIDE) + c;
				u_sram.mem[18'(a)] <= 16'(coef_blk[6'(r * 8 + c)]);
			end
		end
	endtask

	task automatic start_block(input int col, input int row);
		@(posedge Clock);
		start_i <= 1'b1;
		block_col_i <= 6'(col);
		block_row_i <= 5'(row);
		@(posedge Clock);
		start_i <= 1'b0;
	endtask

	task automatic wait_done(output bit ok);
		int n;
		ok = 1'b0;
		n = 0;
		while (!ok && n < TIMEOUT) begin
			@(negedge Clock);
			ok = done_o;
			n++;
		end
	endtask

	task automatic check_block(input int t);
		int base;
		int r;
		int c;
		int a;
		sram_pkg::sram_data_t w;
		idct_pkg::pixel_t p;
		base = int'(sram_pkg::Y_BASE) + tbl_row[t] * 8 * int'(sram_pkg::Y_ROW_STRIDE)
			+ tbl_col[t] * 4;
		for (r = 0; r < 8; r++) begin
			for (c = 0; c < 8; c++) begin
				w = u_sram.mem[18'(base + r * int'(sram_pkg::Y_ROW_STRIDE) + c / 2)];
				// even pixel sits in the high byte
				p = (c % 2 == 0) ? w[15:8] : w[7:0];
				check_pixel(p, idct_pkg::pixel_t'(pix_gold[6'(r * 8 + c)]),
					$sformatf("pixel(%0d,%0d)", r, c));
				if (tbl_flat[t] >= 0) begin
					check_pixel(p, idct_pkg::pixel_t'(tbl_flat[t]),
						$sformatf("flat pixel(%0d,%0d)", r, c));
				end
			end
		end
		// ring of words around the block
		for (r = -1; r <= 8; r++) begin
			for (c = -1; c <= 4; c++) begin
				a = base + r * int'(sram_pkg::Y_ROW_STRIDE) + c;
				if ((r < 0 || r > 7 || c < 0 || c > 3) && a >= 0 && a < MEM_WORDS) begin
					check_word(u_sram.mem[18'(a)], fill_word(a), $sformatf("sram[%0d]", a));
				end
			end
		end
	endtask

	task automatic run_test(input int t, output bit ok);
		int done_base;
		make_block(t);
		golden_idct();
		load_memory(t);
		repeat (2) @(posedge Clock);
		done_base = done_cnt;
		start_block(tbl_col[t], tbl_row[t]);
		if (tbl_busy[t] != 0) begin
			repeat (8) @(posedge Clock);
			start_block(tbl_col[t] + 1, tbl_row[t]);
		end
		wait_done(ok);
		if (!ok) begin
			$display("timeout: test %0d saw no done pulse within %0d cycles", t, TIMEOUT);
			timeouts++;
		end else begin
			// a wrongly accepted busy start would finish a second block in this window
			repeat ((tbl_busy[t] != 0) ? TIMEOUT : 20) @(posedge Clock);
			check_count(done_cnt - done_base, 1, "done_o pulses");
			check_block(t);
		end
	endtask

	initial begin
		bit ok;
		int t;
		ok = 1'b1;
		Resetn <= 1'b0;
		start_i <= 1'b0;
		block_col_i <= '0;
		block_row_i <= '0;
		repeat (4) @(posedge Clock);
		Resetn <= 1'b1;
		for (t = 0; t < N_TESTS && ok; t++) begin
			run_test(t, ok);
		end
		$display("result: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: compile.f
common/idct_pkg.sv
common/sram_pkg.sv
hw/dp_ram.sv
hw/idct/coef_fetch.sv
hw/idct/idct_compute.sv
hw/idct/pixel_writeback.sv
hw/idct_block_top.sv
verification/sram_model.sv
verification/idct_block_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the IDCT block testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/10ps --top-module idct_block_tb \
	-Mdir obj_dir -f compile.f \
	&& ./obj_dir/Vidct_block_tb | tee sim.log \
	|| { echo "build or simulation run failed"; exit 1; }
grep -q "^PASS: all tests$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
